// ==== hdl/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Physical address and data word
`define LSU_ADDR_W 16
`define LSU_DATA_W 32

// L1 data cache geometry, four words per line
`define DC_LINE_W 128
`define DC_SETS 8

// Store queue entries
`define STQ_DEPTH 4

`endif

// ==== hdl/mem_pkg.sv ====
`default_nettype none
`include "lsu_defs.svh"

package mem_pkg;

  typedef enum logic {
    L1D_HIT  = 1'b0,
    L1D_MISS = 1'b1
  } l1d_status_e;

  typedef struct packed {
    logic                   valid;
    logic [`LSU_ADDR_W-1:0] addr;
  } l1d_rd_req_t;

  typedef struct packed {
    l1d_status_e            status;
    logic [`DC_LINE_W-1:0]  line;
  } l1d_rd_resp_t;

  // Store-hit write, one word
  typedef struct packed {
    logic                   valid;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;
  } l1d_wr_t;

  typedef enum logic {
    L2_CMD_RD = 1'b0,
    L2_CMD_WR = 1'b1
  } l2_cmd_e;

  // Line-aligned addr for reads, word address for writes
  typedef struct packed {
    logic                   valid;
    l2_cmd_e                cmd;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;
  } l2_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`DC_LINE_W-1:0]  line;
  } l2_resp_t;

  typedef struct packed {
    logic                   valid;
    l1d_status_e            status;
    logic [`DC_LINE_W-1:0]  line;
  } snoop_resp_t;

endpackage

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none
`include "lsu_defs.svh"

package lsu_pkg;

  // Load request from issue
  typedef struct packed {
    logic                   valid;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [7:0]             tag;
  } ld_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;
  } st_req_t;

  // Load completion
  typedef struct packed {
    logic                   valid;
    logic [7:0]             tag;
    logic [`LSU_DATA_W-1:0] data;
  } done_rpt_t;

  typedef struct packed {
    logic                   hit;
    logic [`LSU_DATA_W-1:0] data;
  } fwd_chk_t;

endpackage

`default_nettype wire

// ==== hdl/dcache.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lsu_defs.svh"

module dcache
  import mem_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  l1d_rd_req_t            i_snoop_rd,
  output l1d_rd_resp_t           o_snoop_rd,
  input  l1d_rd_req_t            i_ld_rd,
  output l1d_rd_resp_t           o_ld_rd,
  input  l1d_wr_t                i_st_wr,
  input  logic [`LSU_ADDR_W-1:0] i_refill_addr,
  input  l2_resp_t               i_refill
);

  localparam int OFF_W  = $clog2(`DC_LINE_W / 8);
  localparam int IDX_W  = $clog2(`DC_SETS);
  localparam int TAG_W  = `LSU_ADDR_W - OFF_W - IDX_W;
  localparam int BOFF_W = $clog2(`LSU_DATA_W / 8);
  localparam int WSEL_W = $clog2(`DC_LINE_W / `LSU_DATA_W);

  logic [`DC_SETS-1:0]   r_valid;
  logic [TAG_W-1:0]      r_tag  [`DC_SETS];
  logic [`DC_LINE_W-1:0] r_line [`DC_SETS];

  logic [IDX_W-1:0]  w_st_idx;
  logic [WSEL_W-1:0] w_st_wsel;
  logic              w_st_hit;
  logic [IDX_W-1:0]  w_rf_idx;

  // Tag compare for one read port
  function automatic l1d_rd_resp_t lookup(input l1d_rd_req_t req);
    logic [IDX_W-1:0] idx;
    l1d_rd_resp_t     resp;
    idx = req.addr[OFF_W +: IDX_W];
    resp.status = (req.valid && r_valid[idx] &&
                   r_tag[idx] == req.addr[`LSU_ADDR_W-1 -: TAG_W]) ? L1D_HIT : L1D_MISS;
    resp.line = r_line[idx];
    return resp;
  endfunction

  always_comb begin
    o_snoop_rd = lookup(i_snoop_rd);
    o_ld_rd    = lookup(i_ld_rd);
  end

  assign w_st_idx  = i_st_wr.addr[OFF_W +: IDX_W];
  assign w_st_wsel = i_st_wr.addr[BOFF_W +: WSEL_W];
  assign w_st_hit  = i_st_wr.valid && r_valid[w_st_idx] &&
                     r_tag[w_st_idx] == i_st_wr.addr[`LSU_ADDR_W-1 -: TAG_W];
  assign w_rf_idx  = i_refill_addr[OFF_W +: IDX_W];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_refill.valid) begin
      r_valid[w_rf_idx] <= 1'b1;
    end
  end

  // Refill installs a whole line, a store hit patches one word
  always_ff @(posedge i_clk) begin
    if (i_refill.valid) begin
      r_tag[w_rf_idx]  <= i_refill_addr[`LSU_ADDR_W-1 -: TAG_W];
      r_line[w_rf_idx] <= i_refill.line;
    end else if (w_st_hit) begin
      r_line[w_st_idx][w_st_wsel * `LSU_DATA_W +: `LSU_DATA_W] <= i_st_wr.data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/miss_unit.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lsu_defs.svh"

module miss_unit
  import mem_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  l1d_rd_req_t            i_miss,
  output l2_req_t                o_l2_rd,
  input  logic                   i_l2_grant,
  input  l2_resp_t               i_l2_resp,
  output l2_resp_t               o_refill,
  output logic [`LSU_ADDR_W-1:0] o_refill_addr,
  output logic                   o_miss_busy
);

  localparam int OFF_W = $clog2(`DC_LINE_W / 8);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_e;

  state_e                 r_state;
  state_e                 w_state_nxt;
  logic [`LSU_ADDR_W-1:0] r_line_addr;

  always_comb begin
    w_state_nxt = r_state;
    case (r_state)
      ST_IDLE: if (i_miss.valid) w_state_nxt = ST_REQ;
      ST_REQ:  if (i_l2_grant) w_state_nxt = ST_WAIT;
      ST_WAIT: if (i_l2_resp.valid) w_state_nxt = ST_IDLE;
      default: w_state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_IDLE;
    end else begin
      r_state <= w_state_nxt;
    end
  end

  // Line address of the missing load
  always_ff @(posedge i_clk) begin
    if (r_state == ST_IDLE && i_miss.valid) begin
      r_line_addr <= {i_miss.addr[`LSU_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    end
  end

  always_comb begin
    o_l2_rd.valid = (r_state == ST_REQ);
    o_l2_rd.cmd   = L2_CMD_RD;
    o_l2_rd.addr  = r_line_addr;
    o_l2_rd.data  = '0;
    o_refill.valid = (r_state == ST_WAIT) && i_l2_resp.valid;
    o_refill.line  = i_l2_resp.line;
  end

  assign o_refill_addr = r_line_addr;
  assign o_miss_busy   = (r_state != ST_IDLE);

endmodule

`default_nettype wire

// ==== hdl/store_queue.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lsu_defs.svh"

module store_queue
  import mem_pkg::*, lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  st_req_t                i_st_req,
  output logic                   o_st_ready,
  input  logic                   i_commit,
  input  logic [`LSU_ADDR_W-1:0] i_fwd_addr,
  output fwd_chk_t               o_fwd,
  input  logic                   i_miss_busy,
  output l2_req_t                o_drain,
  input  logic                   i_drain_grant,
  output l1d_wr_t                o_dc_wr
);

  localparam int PTR_W  = $clog2(`STQ_DEPTH);
  localparam int BOFF_W = $clog2(`LSU_DATA_W / 8);
  localparam logic [PTR_W:0] FULL_CNT = `STQ_DEPTH;

  logic [`LSU_ADDR_W-1:0] r_addr [`STQ_DEPTH];
  logic [`LSU_DATA_W-1:0] r_data [`STQ_DEPTH];

  // Extra top bit tells full from empty
  logic [PTR_W:0] r_head;
  logic [PTR_W:0] r_cmt;
  logic [PTR_W:0] r_tail;
  logic [PTR_W:0] w_count;
  logic           w_push;
  logic           w_pop;

  assign w_count    = r_tail - r_head;
  assign o_st_ready = (w_count != FULL_CNT);
  assign w_push     = i_st_req.valid && o_st_ready;
  assign w_pop      = o_drain.valid && i_drain_grant;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_cmt  <= '0;
      r_tail <= '0;
    end else begin
      if (w_push) r_tail <= r_tail + 1'b1;
      if (i_commit) r_cmt <= r_cmt + 1'b1;
      if (w_pop) r_head <= r_head + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_addr[r_tail[PTR_W-1:0]] <= i_st_req.addr;
      r_data[r_tail[PTR_W-1:0]] <= i_st_req.data;
    end
  end

  // Oldest to youngest, so the last match wins
  always_comb begin : fwd_search
    logic [PTR_W-1:0] idx;
    logic [PTR_W:0]   age;
    o_fwd.hit  = 1'b0;
    o_fwd.data = '0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      idx = r_head[PTR_W-1:0] + PTR_W'(i);
      age = (PTR_W+1)'(i);
      if (age < w_count &&
          r_addr[idx][`LSU_ADDR_W-1:BOFF_W] == i_fwd_addr[`LSU_ADDR_W-1:BOFF_W]) begin
        o_fwd.hit  = 1'b1;
        o_fwd.data = r_data[idx];
      end
    end
  end

  // Drain the committed head, held off while a refill is pending
  always_comb begin
    o_drain.valid = (r_cmt != r_head) && !i_miss_busy;
    o_drain.cmd   = L2_CMD_WR;
    o_drain.addr  = r_addr[r_head[PTR_W-1:0]];
    o_drain.data  = r_data[r_head[PTR_W-1:0]];
    o_dc_wr.valid = w_pop;
    o_dc_wr.addr  = o_drain.addr;
    o_dc_wr.data  = o_drain.data;
  end

endmodule

`default_nettype wire

// ==== hdl/load_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lsu_defs.svh"

module load_pipe
  import mem_pkg::*, lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  ld_req_t                i_ld_req,
  output logic                   o_ld_ready,
  output l1d_rd_req_t            o_dc_rd,
  input  l1d_rd_resp_t           i_dc_rd,
  output logic [`LSU_ADDR_W-1:0] o_fwd_addr,
  input  fwd_chk_t               i_fwd,
  output l1d_rd_req_t            o_miss,
  input  l2_resp_t               i_refill,
  output done_rpt_t              o_ld_done
);

  localparam int BOFF_W = $clog2(`LSU_DATA_W / 8);
  localparam int WSEL_W = $clog2(`DC_LINE_W / `LSU_DATA_W);

  logic                   w_accept;
  logic                   w_stall;
  logic                   w_s0_miss;
  logic [`LSU_DATA_W-1:0] w_s0_word;
  logic [`LSU_DATA_W-1:0] w_refill_word;

  logic                   r_s1_valid;
  logic                   r_s1_miss;
  logic [7:0]             r_s1_tag;
  logic [`LSU_ADDR_W-1:0] r_s1_addr;
  logic [`LSU_DATA_W-1:0] r_s1_data;

  logic                   r_done_valid;
  logic [7:0]             r_done_tag;
  logic [`LSU_DATA_W-1:0] r_done_data;

  // ----------------------------------------------------------------------
  // Stage 0: cache read and store queue search
  // ----------------------------------------------------------------------
  assign o_ld_ready = !(r_s1_valid && r_s1_miss);
  assign w_accept   = i_ld_req.valid && o_ld_ready;
  assign o_fwd_addr = i_ld_req.addr;

  always_comb begin
    o_dc_rd.valid = w_accept;
    o_dc_rd.addr  = i_ld_req.addr;
  end

  // Queued store data wins over the cache line
  assign w_s0_word = i_fwd.hit ? i_fwd.data :
                     i_dc_rd.line[i_ld_req.addr[BOFF_W +: WSEL_W] * `LSU_DATA_W +: `LSU_DATA_W];
  assign w_s0_miss = !i_fwd.hit && (i_dc_rd.status == L1D_MISS);

  // ----------------------------------------------------------------------
  // Stage 1: result register, held on a miss until refill
  // ----------------------------------------------------------------------
  assign w_stall = r_s1_valid && r_s1_miss && !i_refill.valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s1_miss  <= 1'b0;
    end else if (!w_stall) begin
      r_s1_valid <= w_accept;
      r_s1_miss  <= w_accept && w_s0_miss;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!w_stall) begin
      r_s1_tag  <= i_ld_req.tag;
      r_s1_addr <= i_ld_req.addr;
      r_s1_data <= w_s0_word;
    end
  end

  always_comb begin
    o_miss.valid = r_s1_valid && r_s1_miss;
    o_miss.addr  = r_s1_addr;
  end

  assign w_refill_word =
    i_refill.line[r_s1_addr[BOFF_W +: WSEL_W] * `LSU_DATA_W +: `LSU_DATA_W];

  // Done report
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_done_valid <= 1'b0;
    end else begin
      r_done_valid <= r_s1_valid && (!r_s1_miss || i_refill.valid);
    end
  end

  always_ff @(posedge i_clk) begin
    r_done_tag  <= r_s1_tag;
    r_done_data <= r_s1_miss ? w_refill_word : r_s1_data;
  end

  always_comb begin
    o_ld_done.valid = r_done_valid;
    o_ld_done.tag   = r_done_tag;
    o_ld_done.data  = r_done_data;
  end

endmodule

`default_nettype wire

// ==== hdl/l2_req_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lsu_defs.svh"

module l2_req_arbiter
  import mem_pkg::*;
#(
  parameter type REQ_T = l2_req_t
) (
  input  REQ_T i_req [2],
  input  logic i_ready,
  output REQ_T o_req,
  output logic o_grant [2]
);

  // Port 0 always wins
  always_comb begin
    o_req      = i_req[0].valid ? i_req[0] : i_req[1];
    o_grant[0] = i_req[0].valid && i_ready;
    o_grant[1] = !i_req[0].valid && i_req[1].valid && i_ready;
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lsu_defs.svh"

module lsu_top
  import mem_pkg::*, lsu_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  ld_req_t     i_ld_req,
  output logic        o_ld_ready,
  output done_rpt_t   o_ld_done,
  input  st_req_t     i_st_req,
  output logic        o_st_ready,
  input  logic        i_commit,
  input  l1d_rd_req_t i_snoop_req,
  output snoop_resp_t o_snoop_resp,
  output l2_req_t     o_l2_req,
  input  logic        i_l2_ready,
  input  l2_resp_t    i_l2_resp
);

  l1d_rd_req_t            w_dc_ld_req;
  l1d_rd_resp_t           w_dc_ld_resp;
  l1d_rd_resp_t           w_dc_snoop_resp;
  l1d_wr_t                w_dc_wr;
  l1d_rd_req_t            w_miss;
  l2_resp_t               w_refill;
  logic [`LSU_ADDR_W-1:0] w_refill_addr;
  logic                   w_miss_busy;
  logic [`LSU_ADDR_W-1:0] w_fwd_addr;
  fwd_chk_t               w_fwd;

  // Port 0 is the refill read, port 1 the store drain
  l2_req_t                w_l2_in    [2];
  logic                   w_l2_grant [2];

  logic                   r_snoop_valid;
  l1d_status_e            r_snoop_status;
  logic [`DC_LINE_W-1:0]  r_snoop_line;

  // ----------------------------------------------------------------------
  // Load pipe and store queue
  // ----------------------------------------------------------------------
  load_pipe u_load_pipe (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ld_req   (i_ld_req),
    .o_ld_ready (o_ld_ready),
    .o_dc_rd    (w_dc_ld_req),
    .i_dc_rd    (w_dc_ld_resp),
    .o_fwd_addr (w_fwd_addr),
    .i_fwd      (w_fwd),
    .o_miss     (w_miss),
    .i_refill   (w_refill),
    .o_ld_done  (o_ld_done)
  );

  store_queue u_store_queue (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_st_req      (i_st_req),
    .o_st_ready    (o_st_ready),
    .i_commit      (i_commit),
    .i_fwd_addr    (w_fwd_addr),
    .o_fwd         (w_fwd),
    .i_miss_busy   (w_miss_busy),
    .o_drain       (w_l2_in[1]),
    .i_drain_grant (w_l2_grant[1]),
    .o_dc_wr       (w_dc_wr)
  );

  // ----------------------------------------------------------------------
  // Cache, refill and external port
  // ----------------------------------------------------------------------
  dcache u_dcache (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_snoop_rd    (i_snoop_req),
    .o_snoop_rd    (w_dc_snoop_resp),
    .i_ld_rd       (w_dc_ld_req),
    .o_ld_rd       (w_dc_ld_resp),
    .i_st_wr       (w_dc_wr),
    .i_refill_addr (w_refill_addr),
    .i_refill      (w_refill)
  );

  miss_unit u_miss_unit (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_miss        (w_miss),
    .o_l2_rd       (w_l2_in[0]),
    .i_l2_grant    (w_l2_grant[0]),
    .i_l2_resp     (i_l2_resp),
    .o_refill      (w_refill),
    .o_refill_addr (w_refill_addr),
    .o_miss_busy   (w_miss_busy)
  );

  l2_req_arbiter #(
    .REQ_T (l2_req_t)
  ) u_l2_req_arbiter (
    .i_req   (w_l2_in),
    .i_ready (i_l2_ready),
    .o_req   (o_l2_req),
    .o_grant (w_l2_grant)
  );

  // ----------------------------------------------------------------------
  // Snoop response, one cycle after the request
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_snoop_valid <= 1'b0;
    end else begin
      r_snoop_valid <= i_snoop_req.valid;
    end
  end

  // Captures the array before this cycle's writes land
  always_ff @(posedge i_clk) begin
    if (i_snoop_req.valid) begin
      r_snoop_status <= w_dc_snoop_resp.status;
      r_snoop_line   <= w_dc_snoop_resp.line;
    end
  end

  always_comb begin
    o_snoop_resp.valid  = r_snoop_valid;
    o_snoop_resp.status = r_snoop_status;
    o_snoop_resp.line   = r_snoop_line;
  end

endmodule

`default_nettype wire

// ==== test/lsu_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_sva
  import mem_pkg::*;
(
  input logic        i_clk,
  input logic        i_reset_n,
  input l2_req_t     i_l2_req,
  input logic        i_l2_ready,
  input l2_resp_t    i_l2_resp,
  input logic        i_ld_ready,
  input l1d_rd_req_t i_miss,
  input logic        i_miss_busy,
  input l1d_wr_t     i_dc_wr
);

  logic r_rd_busy;

  // Line read accepted and not yet answered
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rd_busy <= 1'b0;
    end else if (i_l2_resp.valid) begin
      r_rd_busy <= 1'b0;
    end else if (i_l2_req.valid && i_l2_ready && i_l2_req.cmd == L2_CMD_RD) begin
      r_rd_busy <= 1'b1;
    end
  end

  // A stalled request holds unless a new miss takes port 0
  l2_req_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_l2_req.valid && !i_l2_ready && !(i_miss.valid && !i_miss_busy)
      |=> $stable(i_l2_req))
    else $error("External request changed while stalled");

  // Load pipe resumes as the miss tracker goes idle
  ld_ready_idle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $fell(i_miss_busy) |-> i_ld_ready)
    else $error("Load ready low after the refill");

  no_wr_in_miss: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_rd_busy |-> !i_dc_wr.valid && !(i_l2_req.valid && i_l2_req.cmd == L2_CMD_WR))
    else $error("Store write issued during a line read");

endmodule

bind lsu_top lsu_sva u_lsu_sva (
  .i_clk       (i_clk),
  .i_reset_n   (i_reset_n),
  .i_l2_req    (o_l2_req),
  .i_l2_ready  (i_l2_ready),
  .i_l2_resp   (i_l2_resp),
  .i_ld_ready  (o_ld_ready),
  .i_miss      (w_miss),
  .i_miss_busy (w_miss_busy),
  .i_dc_wr     (w_dc_wr)
);

`default_nettype wire

// ==== test/lsu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lsu_defs.svh"

module lsu_tb
  import mem_pkg::*, lsu_pkg::*;
;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_CYCLES = 2000;
  localparam int OFF_W      = $clog2(`DC_LINE_W / 8);
  localparam int IDX_W      = $clog2(`DC_SETS);
  localparam int TAG_W      = `LSU_ADDR_W - OFF_W - IDX_W;
  localparam int WSEL_W     = $clog2(`DC_LINE_W / `LSU_DATA_W);
  localparam int MEM_WORDS  = 2 ** (`LSU_ADDR_W - 2);

  // Expected load completion
  typedef struct packed {
    logic [7:0]             tag;
    logic [`LSU_DATA_W-1:0] data;
    logic                   miss;
    logic [31:0]            cyc;
  } ld_exp_t;

  logic        i_clk;
  logic        i_reset_n;
  ld_req_t     i_ld_req;
  logic        o_ld_ready;
  done_rpt_t   o_ld_done;
  st_req_t     i_st_req;
  logic        o_st_ready;
  logic        i_commit;
  l1d_rd_req_t i_snoop_req;
  snoop_resp_t o_snoop_resp;
  l2_req_t     o_l2_req;
  logic        i_l2_ready;
  l2_resp_t    i_l2_resp;

  logic [`LSU_DATA_W-1:0] mem [MEM_WORDS];
  logic                   tm_valid [`DC_SETS];
  logic [TAG_W-1:0]       tm_tag [`DC_SETS];
  st_req_t                sq [$];
  ld_exp_t                ld_q [$];
  snoop_resp_t            exp_snoop;
  integer                 seed;
  int                     cycle;
  int                     sq_cmt;
  int                     resp_cnt;
  logic [7:0]             ld_tag;
  logic                   running;
  logic                   quiet;
  logic                   finished;
  logic                   saw_full;
  logic                   miss_active;
  logic                   rd_expected;
  logic                   rd_pending;
  logic [`LSU_ADDR_W-1:0] rd_addr;
  logic [`DC_LINE_W-1:0]  rd_line;

  lsu_top uut (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_ld_req     (i_ld_req),
    .o_ld_ready   (o_ld_ready),
    .o_ld_done    (o_ld_done),
    .i_st_req     (i_st_req),
    .o_st_ready   (o_st_ready),
    .i_commit     (i_commit),
    .i_snoop_req  (i_snoop_req),
    .o_snoop_resp (o_snoop_resp),
    .o_l2_req     (o_l2_req),
    .i_l2_ready   (i_l2_ready),
    .i_l2_resp    (i_l2_resp)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic fail_now(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // 32 words over 8 lines, two lines per set in sets 0 to 3
  function automatic logic [`LSU_ADDR_W-1:0] pick_addr(input logic [4:0] r);
    return {8'h10, r[4], 1'b0, r[3:2], r[1:0], 2'b00};
  endfunction

  function automatic logic tag_hit(input logic [`LSU_ADDR_W-1:0] addr);
    logic [IDX_W-1:0] idx;
    idx = addr[OFF_W +: IDX_W];
    return tm_valid[idx] && tm_tag[idx] == addr[`LSU_ADDR_W-1 -: TAG_W];
  endfunction

  // Word k of the line sits at bits k*32
  function automatic logic [`DC_LINE_W-1:0] mem_line(input logic [`LSU_ADDR_W-1:0] addr);
    logic [`DC_LINE_W-1:0] line;
    for (int k = 0; k < 2 ** WSEL_W; k++) begin
      line[k * `LSU_DATA_W +: `LSU_DATA_W] = mem[{addr[`LSU_ADDR_W-1:OFF_W], WSEL_W'(k)}];
    end
    return line;
  endfunction

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(CLK_PERIOD * NUM_CYCLES * 20);
    $display("ERROR: watchdog timeout, the run did not complete");
    stop_run();
  end

  // ----------------------------------------------------------------------
  // Reset and end of run
  // ----------------------------------------------------------------------
  initial begin
    seed = 32'h1003ac71;
    i_reset_n = 1'b0;
    i_ld_req = '0;
    i_st_req = '0;
    i_commit = 1'b0;
    i_snoop_req = '0;
    i_l2_ready = 1'b0;
    i_l2_resp = '0;
    exp_snoop = '0;
    {cycle, sq_cmt, resp_cnt, ld_tag} = '0;
    {running, quiet, finished, saw_full} = '0;
    {miss_active, rd_expected, rd_pending, rd_addr, rd_line} = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {~16'(i << 2), 16'(i << 2)};
    end
    for (int s = 0; s < `DC_SETS; s++) begin
      tm_valid[s] = 1'b0;
      tm_tag[s] = '0;
    end
    repeat (2) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    check(o_ld_done.valid, 1'b0, "o_ld_done.valid after reset");
    check(o_snoop_resp.valid, 1'b0, "o_snoop_resp.valid after reset");
    check(o_l2_req.valid, 1'b0, "o_l2_req.valid after reset");
    check(o_ld_ready, 1'b1, "o_ld_ready after reset");
    check(o_st_ready, 1'b1, "o_st_ready after reset");
    running = 1'b1;
    wait (finished);
    if (!saw_full) begin
      $display("ERROR: the store queue never became full");
      stop_run();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Per-cycle model, checks and stimulus
  // ----------------------------------------------------------------------
  always @(posedge i_clk) begin : model
    ld_exp_t     le;
    st_req_t     st;
    logic [31:0] r;
    logic [31:0] r2;
    logic        fwd;
    if (running) begin
      cycle = cycle + 1;
      check(o_st_ready, sq.size() != `STQ_DEPTH, "o_st_ready");
      if (sq.size() == `STQ_DEPTH) saw_full = 1'b1;
      check(o_ld_ready, !miss_active, "o_ld_ready");
      check(o_snoop_resp.valid, exp_snoop.valid, "snoop valid");
      if (exp_snoop.valid) begin
        check(o_snoop_resp.status, exp_snoop.status, "snoop status");
        if (exp_snoop.status == L1D_HIT) check(o_snoop_resp.line, exp_snoop.line, "snoop line");
      end

      // Hits and forwards finish exactly two cycles after acceptance
      if (ld_q.size() != 0 && !ld_q[0].miss && cycle - ld_q[0].cyc == 2) begin
        check(o_ld_done.valid, 1'b1, "hit load done valid");
      end
      if (o_ld_done.valid) begin
        if (ld_q.size() == 0) begin
          fail_now("load done reported with no load in flight");
        end else begin
          le = ld_q.pop_front();
          check(o_ld_done.tag, le.tag, "load tag");
          check(o_ld_done.data, le.data, "load data");
          if (!le.miss) check(cycle - le.cyc, 2, "hit load latency");
        end
      end

      // Accepted load, youngest matching store wins
      if (i_ld_req.valid && o_ld_ready) begin
        fwd = 1'b0;
        le.tag = i_ld_req.tag;
        le.cyc = cycle;
        le.data = mem[i_ld_req.addr[`LSU_ADDR_W-1:2]];
        for (int i = 0; i < sq.size(); i++) begin
          if (sq[i].addr == i_ld_req.addr) begin
            fwd = 1'b1;
            le.data = sq[i].data;
          end
        end
        le.miss = !fwd && !tag_hit(i_ld_req.addr);
        if (le.miss) begin
          miss_active = 1'b1;
          rd_expected = 1'b1;
          rd_addr = {i_ld_req.addr[`LSU_ADDR_W-1:OFF_W], OFF_W'(0)};
        end
        ld_q.push_back(le);
      end

      exp_snoop.valid = i_snoop_req.valid;
      exp_snoop.status = tag_hit(i_snoop_req.addr) ? L1D_HIT : L1D_MISS;
      exp_snoop.line = mem_line(i_snoop_req.addr);

      // Memory model
      if (i_l2_resp.valid) begin
        tm_valid[rd_addr[OFF_W +: IDX_W]] = 1'b1;
        tm_tag[rd_addr[OFF_W +: IDX_W]] = rd_addr[`LSU_ADDR_W-1 -: TAG_W];
        rd_pending = 1'b0;
        miss_active = 1'b0;
        i_l2_resp <= '0;
      end else if (rd_pending) begin
        resp_cnt = resp_cnt - 1;
        if (resp_cnt == 0) begin
          i_l2_resp.valid <= 1'b1;
          i_l2_resp.line <= rd_line;
        end
      end
      if (o_l2_req.valid && i_l2_ready) begin
        if (o_l2_req.cmd == L2_CMD_RD) begin
          if (!rd_expected) begin
            fail_now("line read issued with no miss pending");
          end else begin
            check(o_l2_req.addr, rd_addr, "read line address");
            rd_expected = 1'b0;
            rd_pending = 1'b1;
            rd_line = mem_line(rd_addr);
            resp_cnt = 1 + ($random(seed) & 3);
          end
        end else if (rd_pending) begin
          fail_now("store write issued while a line read is outstanding");
        end else if (sq_cmt == 0) begin
          fail_now("store write issued with no committed store");
        end else begin
          st = sq.pop_front();
          sq_cmt = sq_cmt - 1;
          check(o_l2_req.addr, st.addr, "store write address");
          check(o_l2_req.data, st.data, "store write data");
          mem[st.addr[`LSU_ADDR_W-1:2]] = st.data;
        end
      end

      if (i_st_req.valid && o_st_ready) sq.push_back(i_st_req);
      if (i_commit) sq_cmt = sq_cmt + 1;

      // Next inputs
      r = $random(seed);
      r2 = $random(seed);
      quiet = (cycle >= NUM_CYCLES);
      ld_tag = ld_tag + 8'd1;
      i_ld_req.valid <= !quiet && r[0];
      i_ld_req.addr <= pick_addr(r[5:1]);
      i_ld_req.tag <= ld_tag;
      i_st_req.valid <= !quiet && r[7:6] == 2'b00;
      i_st_req.addr <= pick_addr(r[12:8]);
      i_st_req.data <= r2;
      // Slow commit phases let the store queue fill up
      if (cycle[8] && !quiet) begin
        i_commit <= (sq.size() > sq_cmt) && r[15:13] == 3'b000;
      end else begin
        i_commit <= (sq.size() > sq_cmt) && r[13];
      end
      i_snoop_req.valid <= !quiet && r[17:16] == 2'b00;
      i_snoop_req.addr <= pick_addr(r[22:18]);
      i_l2_ready <= r[24:23] != 2'b00;
      finished = quiet && cycle >= NUM_CYCLES + 2 && ld_q.size() == 0 &&
                 sq.size() == 0 && !rd_pending;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/mem_pkg.sv
hdl/lsu_pkg.sv
hdl/dcache.sv
hdl/miss_unit.sv
hdl/store_queue.sv
hdl/load_pipe.sv
hdl/l2_req_arbiter.sv
hdl/lsu_top.sv
test/lsu_sva.sv
test/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the LSU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module lsu_tb -o lsu_sim

output=$(./obj_dir/lsu_sim 2>&1) || true
echo "$output"
echo "$output" | grep -q "Finished with no errors"
